//--- compile.f
hdl/spmm_dims_pkg.sv
hdl/spmm_ctrl_pkg.sv
hdl/segment_reducer.sv
hdl/pe.sv
hdl/rhs_buffer.sv
hdl/out_buffer.sv
hdl/spmm_control.sv
hdl/spmm_top.sv
dv/spmm_properties.sv
dv/spmm_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module spmm_tb -f compile.f

# passes only if the pass message is printed
run: compile
	@out="$$(./obj_dir/Vspmm_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- dv/spmm_tb.sv
`timescale 1ns/10ps

module spmm_tb;
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    localparam int NUM_TESTS = 4;

    logic  clock;
    logic  out_start;
    logic  rhs_start;
    logic  lhs_start;
    logic  drain_start;
    elem_t rhs_data [ROWS_PER_BEAT][N];
    ptr_t  lhs_ptr  [N];
    idx_t  lhs_col  [N];
    elem_t lhs_data [N];
    logic  rhs_ready;
    logic  lhs_ready;
    logic  out_ready;
    logic  out_valid;
    elem_t out_data [ROWS_PER_BEAT][N];

    // per test the row pointers, column indices and values of A and a back-to-back flag
    ptr_t t_ptr [NUM_TESTS][N] = '{
        '{0, 1, 2, 3, 4, 5, 6, 7},
        '{0, 0, 3, 3, 4, 7, 8, 8},
        '{0, 2, 5, 8, 8, 8, 8, 8},
        '{1, 1, 4, 4, 6, 6, 6, 6}
    };
    idx_t t_col [NUM_TESTS][N] = '{
        '{3, 0, 7, 1, 6, 2, 5, 4},
        '{1, 5, 2, 7, 0, 0, 4, 6},
        '{0, 1, 2, 3, 4, 5, 6, 7},
        '{7, 6, 5, 4, 3, 2, 1, 0}
    };
    elem_t t_data [NUM_TESTS][N] = '{
        '{1, 2, 3, 4, 5, 6, 7, 8},
        '{9, 200, 17, 255, 3, 128, 66, 5},
        '{250, 7, 33, 90, 11, 254, 1, 77},
        '{99, 12, 0, 31, 64, 250, 18, 201}
    };
    logic t_b2b [NUM_TESTS] = '{0, 0, 1, 0};

    // three B slots and their expected C
    elem_t       b_mat [3][N][N];
    elem_t       exp_c [3][N][N];
    logic [31:0] lfsr = 32'hcefd_8afd;
    int          errors = 0;
    int          failed = 0;
    int          start_errors;

    spmm_top i_spmm_top (.*);

    bind spmm_top spmm_properties i_spmm_properties (
        .clock       (clock),
        .out_start   (out_start),
        .rhs_start   (rhs_start),
        .lhs_start   (lhs_start),
        .drain_start (drain_start),
        .rhs_ready   (rhs_ready),
        .lhs_ready   (lhs_ready),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_capture (out_capture)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'ha300_0000;
        end
        return state >> 1;
    endfunction

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %0b actual %0b", $time, name, expected, actual);
            errors++;
        end
    endtask

    // random B and its C from the row-pointer rule
    task automatic make_b(input int t, input int slot);
        ptr_t  last;
        elem_t acc;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                for (int i = 0; i < W; i++) begin
                    lfsr = lfsr_next(lfsr);
                    b_mat[slot][r][c] = {b_mat[slot][r][c][W-2:0], lfsr[0]};
                end
            end
        end
        for (int i = 0; i < N; i++) begin
            last = (i == N - 1) ? ptr_t'(N) : t_ptr[t][i+1];
            for (int j = 0; j < N; j++) begin
                acc = '0;
                for (int k = int'(t_ptr[t][i]); k < int'(last); k++) begin
                    acc = acc + elem_t'(t_data[t][k] * b_mat[slot][t_col[t][k]][j]);
                end
                exp_c[slot][i][j] = acc;
            end
        end
    endtask

    task automatic load_b(input int slot);
        while (rhs_ready !== 1'b1) @(negedge clock);
        rhs_start = 1'b1;
        for (int b = 0; b < BEATS; b++) begin
            for (int r = 0; r < ROWS_PER_BEAT; r++) begin
                for (int c = 0; c < N; c++) begin
                    rhs_data[r][c] = b_mat[slot][b * ROWS_PER_BEAT + r][c];
                end
            end
            @(negedge clock);
            rhs_start = 1'b0;
        end
    endtask

    task automatic issue_a(input int t);
        while (lhs_ready !== 1'b1) @(negedge clock);
        lhs_ptr = t_ptr[t];
        lhs_col = t_col[t];
        lhs_data = t_data[t];
        lhs_start = 1'b1;
        @(negedge clock);
        lhs_start = 1'b0;
        check_flag("lhs_ready", 1'b0, lhs_ready);
    endtask

    task automatic drain_check(input int slot);
        int beats;
        while (out_ready !== 1'b1) @(negedge clock);
        drain_start = 1'b1;
        @(negedge clock);
        drain_start = 1'b0;
        beats = 0;
        while (out_valid === 1'b1 && beats <= BEATS) begin
            for (int r = 0; r < ROWS_PER_BEAT && beats < BEATS; r++) begin
                for (int c = 0; c < N; c++) begin
                    if (out_data[r][c] !== exp_c[slot][beats * ROWS_PER_BEAT + r][c]) begin
                        $display("[FAIL] %0t out_data[%0d][%0d] beat %0d expected %0d actual %0d",
                                 $time, r, c, beats, exp_c[slot][beats * ROWS_PER_BEAT + r][c],
                                 out_data[r][c]);
                        errors++;
                    end
                end
            end
            beats++;
            @(negedge clock);
        end
        if (beats != BEATS) begin
            $display("[FAIL] %0t out_valid cycles expected %0d actual %0d", $time, BEATS, beats);
            errors++;
        end
    endtask

    initial begin
        clock = 1'b0;
        out_start = 1'b1;
        rhs_start = 1'b0;
        lhs_start = 1'b0;
        drain_start = 1'b0;
        rhs_data = '{default: '0};
        lhs_ptr = '{default: '0};
        lhs_col = '{default: '0};
        lhs_data = '{default: '0};
        repeat (4) @(negedge clock);
        out_start = 1'b0;
        @(negedge clock);
        check_flag("rhs_ready", 1'b1, rhs_ready);
        check_flag("lhs_ready", 1'b0, lhs_ready);
        check_flag("out_ready", 1'b0, out_ready);
        check_flag("out_valid", 1'b0, out_valid);

        for (int t = 0; t < NUM_TESTS; t++) begin
            start_errors = errors;
            make_b(t, 0);
            load_b(0);
            issue_a(t);
            if (t_b2b[t]) begin
                // second B goes in while the first compute runs
                make_b(t, 1);
                load_b(1);
                issue_a(t);
                make_b(t, 2);
                load_b(2);
                repeat (PE_LATENCY + 1) @(negedge clock);
                // both output buffers full so these lhs strobes must be ignored
                lhs_start = 1'b1;
                repeat (4) begin
                    check_flag("lhs_ready", 1'b0, lhs_ready);
                    @(negedge clock);
                end
                lhs_start = 1'b0;
                drain_check(0);
                drain_check(1);
                issue_a(t);
                drain_check(2);
            end else begin
                drain_check(0);
            end
            // every B consumed
            check_flag("lhs_ready", 1'b0, lhs_ready);
            if (errors != start_errors) begin
                failed++;
            end
            $display("test %0d: %s", t, (errors == start_errors) ? "ok" : "mismatch");
        end

        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // about 40 cycles per table entry
    initial begin
        repeat (NUM_TESTS * 40) @(posedge clock);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- dv/spmm_properties.sv
`timescale 1ns/10ps

module spmm_properties (
    input logic clock,
    input logic out_start,
    input logic rhs_start,
    input logic lhs_start,
    input logic drain_start,
    input logic rhs_ready,
    input logic lhs_ready,
    input logic out_ready,
    input logic out_valid,
    input logic out_capture
);
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    // length of the current out_valid run
    int valid_len;

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            valid_len <= 0;
        end else if (out_valid) begin
            valid_len <= valid_len + 1;
        end else begin
            valid_len <= 0;
        end
    end

    // an ignored lhs_start never leads to a capture
    lhs_ignored_when_busy: assert property (@(posedge clock) disable iff (out_start)
        lhs_start && !lhs_ready |-> ##(PE_LATENCY + 1) !out_capture)
        else $error("lhs_start accepted while lhs_ready was low");

    drain_starts_valid: assert property (@(posedge clock) disable iff (out_start)
        drain_start && out_ready |=> $rose(out_valid))
        else $error("out_valid did not rise after an accepted drain_start");

    drain_length: assert property (@(posedge clock) disable iff (out_start)
        $fell(out_valid) |-> valid_len == BEATS)
        else $error("out_valid run length differs from the beat count");

    rhs_busy_after_start: assert property (@(posedge clock) disable iff (out_start)
        rhs_start && rhs_ready |=> !rhs_ready)
        else $error("rhs_ready still high after an accepted rhs_start");

endmodule

//--- hdl/spmm_top.sv
`timescale 1ns/10ps

module spmm_top (
    input  logic                 clock,
    input  logic                 out_start,
    input  logic                 rhs_start,
    input  logic                 lhs_start,
    input  logic                 drain_start,
    input  spmm_dims_pkg::elem_t rhs_data [spmm_dims_pkg::ROWS_PER_BEAT][spmm_dims_pkg::N],
    input  spmm_dims_pkg::ptr_t  lhs_ptr  [spmm_dims_pkg::N],
    input  spmm_dims_pkg::idx_t  lhs_col  [spmm_dims_pkg::N],
    input  spmm_dims_pkg::elem_t lhs_data [spmm_dims_pkg::N],
    output logic                 rhs_ready,
    output logic                 lhs_ready,
    output logic                 out_ready,
    output logic                 out_valid,
    output spmm_dims_pkg::elem_t out_data [spmm_dims_pkg::ROWS_PER_BEAT][spmm_dims_pkg::N]
);
    import spmm_dims_pkg::*;

    logic  rhs_load;
    logic  rhs_wr_sel;
    logic  rhs_rd_sel;
    logic  load_done;
    logic  out_capture;
    logic  out_wr_sel;
    logic  out_drain;
    logic  out_rd_sel;
    logic  drain_done;
    elem_t rhs_columns [N][N];
    elem_t pe_columns  [N][N];

    spmm_control i_spmm_control (
        .clock       (clock),
        .out_start   (out_start),
        .rhs_start   (rhs_start),
        .lhs_start   (lhs_start),
        .drain_start (drain_start),
        .load_done   (load_done),
        .drain_done  (drain_done),
        .rhs_ready   (rhs_ready),
        .lhs_ready   (lhs_ready),
        .out_ready   (out_ready),
        .rhs_load    (rhs_load),
        .rhs_wr_sel  (rhs_wr_sel),
        .rhs_rd_sel  (rhs_rd_sel),
        .out_capture (out_capture),
        .out_wr_sel  (out_wr_sel),
        .out_drain   (out_drain),
        .out_rd_sel  (out_rd_sel)
    );

    rhs_buffer i_rhs_buffer (
        .clock       (clock),
        .out_start   (out_start),
        .rhs_load    (rhs_load),
        .rhs_wr_sel  (rhs_wr_sel),
        .rhs_data    (rhs_data),
        .rhs_rd_sel  (rhs_rd_sel),
        .rhs_columns (rhs_columns),
        .load_done   (load_done)
    );

    // one pe per column of C
    for (genvar i = 0; i < N; i++) begin : g_pe
        pe i_pe (
            .clock      (clock),
            .out_start  (out_start),
            .lhs_start  (lhs_start),
            .lhs_ptr    (lhs_ptr),
            .lhs_col    (lhs_col),
            .lhs_data   (lhs_data),
            .rhs_column (rhs_columns[i]),
            .column_out (pe_columns[i])
        );
    end

    out_buffer i_out_buffer (
        .clock       (clock),
        .out_start   (out_start),
        .out_capture (out_capture),
        .out_wr_sel  (out_wr_sel),
        .pe_columns  (pe_columns),
        .out_drain   (out_drain),
        .out_rd_sel  (out_rd_sel),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .drain_done  (drain_done)
    );

endmodule

//--- hdl/spmm_control.sv
`timescale 1ns/10ps

module spmm_control (
    input  logic clock,
    input  logic out_start,
    input  logic rhs_start,
    input  logic lhs_start,
    input  logic drain_start,
    input  logic load_done,
    input  logic drain_done,
    output logic rhs_ready,
    output logic lhs_ready,
    output logic out_ready,
    output logic rhs_load,
    output logic rhs_wr_sel,
    output logic rhs_rd_sel,
    output logic out_capture,
    output logic out_wr_sel,
    output logic out_drain,
    output logic out_rd_sel
);
    import spmm_ctrl_pkg::*;

    typedef logic [$clog2(PE_LATENCY + 2)-1:0] cnt_t;

    rhs_state_e rhs_state [2];
    out_state_e out_state [2];
    cnt_t       comp_cnt;
    logic       rhs_acc;
    logic       lhs_acc;
    logic       drain_acc;
    logic       rhs_pick;
    logic       out_pick;
    logic       load_sel;
    logic       drain_sel;

    assign rhs_acc = rhs_start && rhs_ready;
    assign lhs_acc = lhs_start && lhs_ready;
    assign drain_acc = drain_start && out_ready;

    assign rhs_ready = rhs_state[0] != rhs_loading && rhs_state[1] != rhs_loading
                       && (rhs_state[0] == rhs_empty || rhs_state[1] == rhs_empty);
    assign lhs_ready = (rhs_state[0] == rhs_loaded || rhs_state[1] == rhs_loaded)
                       && (out_state[0] == out_free || out_state[1] == out_free)
                       && comp_cnt == '0;
    // one drain at a time
    assign out_ready = (out_state[0] == out_full || out_state[1] == out_full)
                       && out_state[0] != out_draining && out_state[1] != out_draining;

    // buffer 0 wins when both qualify
    assign rhs_wr_sel = rhs_state[0] != rhs_empty;
    assign rhs_pick = rhs_state[0] != rhs_loaded;
    assign out_pick = out_state[0] != out_free;
    assign out_rd_sel = out_state[0] != out_full;
    assign load_sel = rhs_state[0] != rhs_loading;
    assign drain_sel = out_state[0] != out_draining;

    assign rhs_load = rhs_acc;
    assign out_drain = drain_acc;
    assign out_capture = comp_cnt == cnt_t'(1);

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            comp_cnt <= '0;
            rhs_rd_sel <= 1'b0;
            out_wr_sel <= 1'b0;
        end else if (lhs_acc) begin
            comp_cnt <= cnt_t'(PE_LATENCY + 1);
            rhs_rd_sel <= rhs_pick;
            out_wr_sel <= out_pick;
        end else if (comp_cnt != '0) begin
            comp_cnt <= comp_cnt - 1'b1;
        end
    end

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            rhs_state[0] <= rhs_empty;
            rhs_state[1] <= rhs_empty;
            out_state[0] <= out_free;
            out_state[1] <= out_free;
        end else begin
            if (rhs_acc) begin
                rhs_state[rhs_wr_sel] <= rhs_loading;
            end
            if (load_done) begin
                rhs_state[load_sel] <= rhs_loaded;
            end
            if (lhs_acc) begin
                rhs_state[rhs_pick] <= rhs_in_use;
                out_state[out_pick] <= out_computing;
            end
            // compute retires, B is consumed
            if (out_capture) begin
                rhs_state[rhs_rd_sel] <= rhs_empty;
                out_state[out_wr_sel] <= out_full;
            end
            if (drain_acc) begin
                out_state[out_rd_sel] <= out_draining;
            end
            if (drain_done) begin
                out_state[drain_sel] <= out_free;
            end
        end
    end

endmodule

//--- hdl/out_buffer.sv
`timescale 1ns/10ps

module out_buffer (
    input  logic                 clock,
    input  logic                 out_start,
    input  logic                 out_capture,
    input  logic                 out_wr_sel,
    input  spmm_dims_pkg::elem_t pe_columns [spmm_dims_pkg::N][spmm_dims_pkg::N],
    input  logic                 out_drain,
    input  logic                 out_rd_sel,
    output spmm_dims_pkg::elem_t out_data   [spmm_dims_pkg::ROWS_PER_BEAT][spmm_dims_pkg::N],
    output logic                 out_valid,
    output logic                 drain_done
);
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    // buffer, column, row
    elem_t     mem [2][N][N];
    logic      rd_sel_q;
    beat_cnt_t beat;
    logic      send;
    logic      rd_buf;
    beat_cnt_t rd_beat;

    // beat holds the next beat to present
    assign send = out_drain || (out_valid && beat != beat_cnt_t'(BEATS));
    assign rd_buf = out_drain ? out_rd_sel : rd_sel_q;
    assign rd_beat = out_drain ? '0 : beat;

    always_ff @(posedge clock) begin
        if (out_capture) begin
            mem[out_wr_sel] <= pe_columns;
        end
    end

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            out_valid <= 1'b0;
            drain_done <= 1'b0;
            rd_sel_q <= 1'b0;
            beat <= '0;
        end else begin
            out_valid <= send;
            drain_done <= send && (rd_beat == beat_cnt_t'(BEATS - 1));
            if (send) begin
                beat <= rd_beat + 1'b1;
            end
            if (out_drain) begin
                rd_sel_q <= out_rd_sel;
            end
        end
    end

    // rows go out in ascending order
    always_ff @(posedge clock) begin
        if (send) begin
            for (int r = 0; r < ROWS_PER_BEAT; r++) begin
                for (int c = 0; c < N; c++) begin
                    out_data[r][c] <= mem[rd_buf][c][int'(rd_beat) * ROWS_PER_BEAT + r];
                end
            end
        end
    end

endmodule

//--- hdl/rhs_buffer.sv
`timescale 1ns/10ps

module rhs_buffer (
    input  logic                 clock,
    input  logic                 out_start,
    input  logic                 rhs_load,
    input  logic                 rhs_wr_sel,
    input  spmm_dims_pkg::elem_t rhs_data    [spmm_dims_pkg::ROWS_PER_BEAT][spmm_dims_pkg::N],
    input  logic                 rhs_rd_sel,
    output spmm_dims_pkg::elem_t rhs_columns [spmm_dims_pkg::N][spmm_dims_pkg::N],
    output logic                 load_done
);
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    // buffer, column, row
    elem_t     mem [2][N][N];
    logic      busy;
    logic      wr_sel_q;
    beat_cnt_t beat;
    logic      wr_now;
    logic      wr_buf;
    beat_cnt_t wr_beat;

    // beat 0 arrives with rhs_load
    assign wr_now = rhs_load || busy;
    assign wr_buf = rhs_load ? rhs_wr_sel : wr_sel_q;
    assign wr_beat = rhs_load ? '0 : beat;

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            busy <= 1'b0;
            wr_sel_q <= 1'b0;
            beat <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (rhs_load) begin
                wr_sel_q <= rhs_wr_sel;
            end
            if (wr_now) begin
                if (wr_beat == beat_cnt_t'(BEATS - 1)) begin
                    busy <= 1'b0;
                    load_done <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    beat <= wr_beat + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_now) begin
            for (int r = 0; r < ROWS_PER_BEAT; r++) begin
                for (int c = 0; c < N; c++) begin
                    mem[wr_buf][c][int'(wr_beat) * ROWS_PER_BEAT + r] <= rhs_data[r][c];
                end
            end
        end
    end

    // column-major view for the pe array
    assign rhs_columns = mem[rhs_rd_sel];

endmodule

//--- hdl/pe.sv
`timescale 1ns/10ps

module pe (
    input  logic                 clock,
    input  logic                 out_start,
    input  logic                 lhs_start,
    input  spmm_dims_pkg::ptr_t  lhs_ptr    [spmm_dims_pkg::N],
    input  spmm_dims_pkg::idx_t  lhs_col    [spmm_dims_pkg::N],
    input  spmm_dims_pkg::elem_t lhs_data   [spmm_dims_pkg::N],
    input  spmm_dims_pkg::elem_t rhs_column [spmm_dims_pkg::N],
    output spmm_dims_pkg::elem_t column_out [spmm_dims_pkg::N]
);
    import spmm_dims_pkg::*;

    ptr_t  ptr_q     [N];
    idx_t  col_q     [N];
    elem_t data_q    [N];
    ptr_t  end_c     [N];
    logic  split_c   [N];
    elem_t products  [N];
    logic  split     [N];
    ptr_t  row_start [N];
    ptr_t  row_end   [N];

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            for (int i = 0; i < N; i++) begin
                ptr_q[i] <= '0;
            end
        end else if (lhs_start) begin
            ptr_q <= lhs_ptr;
        end
    end

    always_ff @(posedge clock) begin
        if (lhs_start) begin
            col_q <= lhs_col;
            data_q <= lhs_data;
        end
    end

    // last row ends at N
    always_comb begin
        for (int i = 0; i < N - 1; i++) begin
            end_c[i] = ptr_q[i+1];
        end
        end_c[N-1] = ptr_t'(N);
        for (int k = 0; k < N; k++) begin
            split_c[k] = 1'b0;
        end
        for (int i = 0; i < N; i++) begin
            if (end_c[i] > ptr_q[i]) begin
                split_c[idx_t'(ptr_q[i])] = 1'b1;
            end
        end
    end

    // gather and multiply, wraps to W bits
    always_ff @(posedge clock) begin
        for (int k = 0; k < N; k++) begin
            products[k] <= data_q[k] * rhs_column[col_q[k]];
        end
    end

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            for (int i = 0; i < N; i++) begin
                split[i] <= 1'b0;
                row_start[i] <= '0;
                row_end[i] <= '0;
            end
        end else begin
            split <= split_c;
            row_start <= ptr_q;
            row_end <= end_c;
        end
    end

    segment_reducer i_segment_reducer (
        .clock     (clock),
        .out_start (out_start),
        .products  (products),
        .split     (split),
        .row_start (row_start),
        .row_end   (row_end),
        .sums      (column_out)
    );

endmodule

//--- hdl/segment_reducer.sv
`timescale 1ns/10ps

module segment_reducer (
    input  logic                 clock,
    input  logic                 out_start,
    input  spmm_dims_pkg::elem_t products  [spmm_dims_pkg::N],
    input  logic                 split     [spmm_dims_pkg::N],
    input  spmm_dims_pkg::ptr_t  row_start [spmm_dims_pkg::N],
    input  spmm_dims_pkg::ptr_t  row_end   [spmm_dims_pkg::N],
    output spmm_dims_pkg::elem_t sums      [spmm_dims_pkg::N]
);
    import spmm_dims_pkg::*;

    elem_t stage_in [LG_N][N];
    elem_t prefix   [LG_N][N];
    logic  split_d  [LG_N][N];
    ptr_t  start_d  [LG_N][N];
    ptr_t  end_d    [LG_N][N];
    elem_t seg      [N];

    always_comb begin
        stage_in[0] = products;
        for (int s = 1; s < LG_N; s++) begin
            stage_in[s] = prefix[s-1];
        end
    end

    // log-step scan, stage s reaches 2^s lanes back
    always_ff @(posedge clock) begin
        for (int s = 0; s < LG_N; s++) begin
            for (int j = 0; j < N; j++) begin
                if (j >= (1 << s)) begin
                    prefix[s][j] <= stage_in[s][j] + stage_in[s][j - (1 << s)];
                end else begin
                    prefix[s][j] <= stage_in[s][j];
                end
            end
        end
    end

    // row bounds follow the scan
    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            for (int s = 0; s < LG_N; s++) begin
                for (int j = 0; j < N; j++) begin
                    split_d[s][j] <= 1'b0;
                    start_d[s][j] <= '0;
                    end_d[s][j] <= '0;
                end
            end
        end else begin
            split_d[0] <= split;
            start_d[0] <= row_start;
            end_d[0] <= row_end;
            for (int s = 1; s < LG_N; s++) begin
                split_d[s] <= split_d[s-1];
                start_d[s] <= start_d[s-1];
                end_d[s] <= end_d[s-1];
            end
        end
    end

    // P[end-1] - P[start-1], zero when the row owns nothing
    always_comb begin
        for (int i = 0; i < N; i++) begin
            seg[i] = '0;
            if (end_d[LG_N-1][i] > start_d[LG_N-1][i]
                    && split_d[LG_N-1][idx_t'(start_d[LG_N-1][i])]) begin
                seg[i] = prefix[LG_N-1][idx_t'(end_d[LG_N-1][i] - 1'b1)];
                if (start_d[LG_N-1][i] != '0) begin
                    seg[i] = seg[i] - prefix[LG_N-1][idx_t'(start_d[LG_N-1][i] - 1'b1)];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        sums <= seg;
    end

endmodule

//--- hdl/spmm_ctrl_pkg.sv
package spmm_ctrl_pkg;

    // rhs buffer life cycle
    typedef enum logic [1:0] {
        rhs_empty,
        rhs_loading,
        rhs_loaded,
        rhs_in_use
    } rhs_state_e;

    // output buffer life cycle
    typedef enum logic [1:0] {
        out_free,
        out_computing,
        out_full,
        out_draining
    } out_state_e;

    // lhs_start edge to pe result register
    localparam int PE_LATENCY = spmm_dims_pkg::LG_N + 2;

    // counts load and drain beats, up to BEATS
    typedef logic [$clog2(spmm_dims_pkg::BEATS + 1)-1:0] beat_cnt_t;

endpackage

//--- hdl/spmm_dims_pkg.sv
package spmm_dims_pkg;

    // matrix dimension
    localparam int N = 8;

    // element width
    localparam int W = 8;

    localparam int LG_N = $clog2(N);

    // rows moved per load or drain beat
    localparam int ROWS_PER_BEAT = 4;
    localparam int BEATS = N / ROWS_PER_BEAT;

    // one matrix element, arithmetic wraps at W bits
    typedef logic [W-1:0] elem_t;

    // row or column index
    typedef logic [LG_N-1:0] idx_t;

    // row pointer, one bit wider so it can hold N
    typedef logic [LG_N:0] ptr_t;

endpackage
